// ==== sources.f ====
hdl/rvPkg.sv
hdl/fetchUnit.sv
hdl/instrQueue.sv
hdl/controlDecoder.sv
hdl/immGen.sv
hdl/registerFile.sv
hdl/decodeStage.sv
hdl/rvDecodeTop.sv
test/rvDecodeTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= rvDecodeTb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= sources.f
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/rvDecodeTb.sv ====
// Front end testbench
module rvDecodeTb import rvPkg::*; ();

    localparam int waitLimit = 400;
    localparam int busOpen = 0;
    localparam int busIdle = 1;
    localparam int enoughTransfers = 2;

    logic                    clock;
    logic                    rstN;
    logic                    wbCyc;
    logic                    wbStb;
    logic                    wbWe;
    logic [xlen-1:0]         wbAdr;
    logic [xlen-1:0]         wbDatIn;
    logic                    wbAck;
    logic                    redirect;
    logic [xlen-1:0]         redirectPc;
    logic                    wbRegWrite;
    logic [regAddrWidth-1:0] wbRegAddr;
    logic [xlen-1:0]         wbRegData;
    logic                    decReady;
    logic                    decValid;
    logic [xlen-1:0]         decPc;
    instrClass               decClass;
    logic                    decRegWrite;
    logic                    decAluSrc;
    logic                    decMemRead;
    logic                    decMemWrite;
    memWidth                 decMemSize;
    logic                    decMemUnsigned;
    logic [3:0]              decFuncCode;
    logic [regAddrWidth-1:0] decRs1;
    logic [regAddrWidth-1:0] decRs2;
    logic [regAddrWidth-1:0] decRd;
    logic [xlen-1:0]         decRs1Data;
    logic [xlen-1:0]         decRs2Data;
    logic [xlen-1:0]         decImm;

    // Instruction memory and register mirrors
    logic [31:0] mem [64];
    logic [31:0] shadow [32];
    logic [31:0] armedRegs [32];
    logic [31:0] loadedRegs [32];

    logic [31:0] lfsr = 32'hbdf1;
    logic [31:0] expPc = resetPc;
    logic [31:0] heldPc;
    logic [31:0] heldImm;
    logic [31:0] heldRs1Data;
    logic        loadArmed = 1'b0;
    logic        holdArmed = 1'b0;
    logic        busSeen = 1'b0;
    logic        holdReady = 1'b0;
    logic        randomWrites = 1'b0;
    int          waitLeft = -1;
    int          stallLeft = 0;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    int          transfers = 0;
    int          transferGoal = 0;

    rvDecodeTop dut_i (.*);

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // Taps 32 22 2 1
    function automatic logic lfsrStep();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsrStep()};
        end
        return v;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Flags are {regWrite, aluSrc, memRead, memWrite, memUnsigned}
    function automatic void expectedDecode(input logic [31:0] instr, output instrClass cls,
            output logic [4:0] flags, output memWidth size, output logic [3:0] func,
            output logic [14:0] regIdx, output logic [31:0] imm);
        logic [2:0]         f3;
        logic signed [11:0] immI;
        logic signed [11:0] immS;
        logic signed [12:0] immB;
        logic signed [20:0] immJ;
        f3 = instr[14:12];
        immI = instr[31:20];
        immS = {instr[31:25], instr[11:7]};
        immB = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        immJ = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        func = {instr[30], f3};
        regIdx = {instr[19:15], instr[24:20], instr[11:7]};
        cls = classIllegal;
        flags = 5'b00000;
        size = memNone;
        imm = 32'd0;
        case (instr[6:0])
            opOp: begin
                cls = classAlu;
                flags = 5'b10000;
            end
            opOpImm: begin
                cls = classAluImm;
                flags = 5'b11000;
                imm = 32'(immI);
            end
            opLoad: begin
                imm = 32'(immI);
                // Widths 0 1 2 signed, 4 5 unsigned
                if (f3 != 3'd3 && f3 < 3'd6) begin
                    cls = classLoad;
                    flags = {4'b1110, f3[2]};
                    size = (f3[1:0] == 2'd0) ? memByte : (f3[1:0] == 2'd1) ? memHalf : memWord;
                end
            end
            opStore: begin
                imm = 32'(immS);
                if (f3 < 3'd3) begin
                    cls = classStore;
                    flags = 5'b01010;
                    size = (f3 == 3'd0) ? memByte : (f3 == 3'd1) ? memHalf : memWord;
                end
            end
            opBranch: begin
                cls = classBranch;
                imm = 32'(immB);
            end
            opJal: begin
                cls = classJal;
                flags = 5'b10000;
                imm = 32'(immJ);
            end
            opJalr: begin
                cls = classJalr;
                flags = 5'b11000;
                imm = 32'(immI);
            end
            opLui, opAuipc: begin
                cls = (instr[6:0] == opLui) ? classLui : classAuipc;
                flags = 5'b11000;
                imm = {instr[31:12], 12'h000};
            end
            default: cls = classIllegal;
        endcase
    endfunction

    task automatic fillMemory();
        logic [6:0]  ops [9];
        logic [31:0] pick;
        logic [6:0]  op;
        ops = '{opLoad, opStore, opOp, opOpImm, opBranch, opJal, opJalr, opLui, opAuipc};
        mem[0]  = {7'h20, 5'd3, 5'd2, 3'd0, 5'd1, opOp};
        mem[1]  = {12'hff4, 5'd6, 3'd0, 5'd5, opOpImm};
        mem[2]  = {12'hfff, 5'd8, 3'd0, 5'd7, opLoad};
        mem[3]  = {12'd20, 5'd9, 3'd1, 5'd10, opLoad};
        mem[4]  = {12'd2047, 5'd11, 3'd2, 5'd12, opLoad};
        mem[5]  = {12'h800, 5'd13, 3'd4, 5'd14, opLoad};
        mem[6]  = {12'd4, 5'd0, 3'd5, 5'd15, opLoad};
        mem[7]  = {12'd8, 5'd1, 3'd3, 5'd2, opLoad};
        mem[8]  = {7'h7f, 5'd16, 5'd17, 3'd0, 5'd31, opStore};
        mem[9]  = {7'd1, 5'd18, 5'd19, 3'd1, 5'd0, opStore};
        mem[10] = {7'h40, 5'd20, 5'd21, 3'd2, 5'd4, opStore};
        mem[11] = {7'd0, 5'd1, 5'd2, 3'd4, 5'd3, opStore};
        mem[12] = {7'h7f, 5'd22, 5'd23, 3'd0, 5'd29, opBranch};
        mem[13] = {1'b1, 10'h3fe, 1'b1, 8'hff, 5'd1, opJal};
        mem[14] = {12'hffc, 5'd1, 3'd0, 5'd0, opJalr};
        mem[15] = {20'hfffff, 5'd24, opLui};
        mem[16] = {20'h12345, 5'd25, opAuipc};
        // Fence, CSR write and a compressed word all decode as illegal
        mem[17] = 32'h0ff0000f;
        mem[18] = {12'h300, 5'd1, 3'd1, 5'd0, 7'b1110011};
        mem[19] = 32'h00004501;
        mem[20] = {7'd0, 5'd28, 5'd27, 3'd7, 5'd26, opOp};
        mem[21] = {12'd0, 5'd3, 3'd7, 5'd4, opLoad};
        for (int i = 22; i < 64; i++) begin
            pick = randBits(4);
            op = (pick < 32'd9) ? ops[pick] : 7'(randBits(7));
            mem[i] = {25'(randBits(25)), op};
        end
    endtask

    // Wishbone slave with 0 to 3 wait states
    task automatic serveBus();
        if (!rstN || wbAck) begin
            wbAck = 1'b0;
            waitLeft = -1;
        end else if (wbCyc && wbStb) begin
            if (waitLeft < 0) begin
                waitLeft = int'(randBits(2));
            end
            if (waitLeft == 0) begin
                wbAck = 1'b1;
                wbDatIn = mem[wbAdr[7:2]];
                waitLeft = -1;
            end else begin
                waitLeft--;
            end
        end
    endtask

    task automatic stepCycle();
        @(negedge clock);
        redirect = 1'b0;
        serveBus();
        if (holdReady) begin
            decReady = 1'b0;
        end else if (stallLeft > 0) begin
            decReady = 1'b0;
            stallLeft--;
        end else if (randBits(3) == 32'd0) begin
            stallLeft = int'(randBits(3));
            decReady = 1'b0;
        end else begin
            decReady = 1'b1;
        end
        wbRegWrite = randomWrites ? lfsrStep() : 1'b0;
        if (randomWrites) begin
            wbRegAddr = 5'(randBits(5));
            wbRegData = randBits(32);
        end
    endtask

    function automatic logic waitDone(input int kind);
        case (kind)
            busOpen: return wbCyc && !wbAck;
            busIdle: return !wbCyc;
            default: return transfers >= transferGoal;
        endcase
    endfunction

    task automatic waitFor(input int kind, input string what);
        int n;
        n = 0;
        while (timeouts == 0 && !waitDone(kind) && n < waitLimit) begin
            stepCycle();
            n++;
        end
        if (timeouts == 0 && !waitDone(kind)) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for %s", n, what);
        end
    endtask

    task automatic compareTransfer();
        logic [31:0] instr;
        logic [31:0] imm;
        instrClass   cls;
        memWidth     size;
        logic [4:0]  flags;
        logic [3:0]  func;
        logic [14:0] regIdx;
        instr = mem[expPc[7:2]];
        expectedDecode(instr, cls, flags, size, func, regIdx, imm);
        check("decPc", decPc, expPc);
        check("decClass", 32'(decClass), 32'(cls));
        check("control bits", 32'({decRegWrite, decAluSrc, decMemRead, decMemWrite,
            decMemUnsigned}), 32'(flags));
        check("decMemSize", 32'(decMemSize), 32'(size));
        check("decFuncCode", 32'(decFuncCode), 32'(func));
        check("register indices", 32'({decRs1, decRs2, decRd}), 32'(regIdx));
        check("decImm", decImm, imm);
        check("decRs1Data", decRs1Data, loadedRegs[regIdx[14:10]]);
        check("decRs2Data", decRs2Data, loadedRegs[regIdx[9:5]]);
        expPc = expPc + 32'd4;
        transfers++;
    endtask

    // Values seen here belong to the cycle that ends at this edge
    always @(posedge clock) begin
        if (loadArmed && decValid) begin
            loadedRegs = armedRegs;
        end
        if (rstN) begin
            check("wbWe", 32'(wbWe), 32'd0);
            if (wbCyc && !busSeen) begin
                busSeen = 1'b1;
                check("first bus address", wbAdr, resetPc);
            end
            if (holdArmed) begin
                check("stalled decValid", 32'(decValid), 32'd1);
                check("stalled decPc", decPc, heldPc);
                check("stalled decImm", decImm, heldImm);
                check("stalled decRs1Data", decRs1Data, heldRs1Data);
            end
            if (decValid && decReady) begin
                compareTransfer();
            end
            holdArmed = decValid && !decReady && !redirect;
            heldPc = decPc;
            heldImm = decImm;
            heldRs1Data = decRs1Data;
            if (redirect) begin
                expPc = {redirectPc[31:2], 2'b00};
            end
        end
        if (rstN && wbRegWrite && wbRegAddr != 5'd0) begin
            shadow[wbRegAddr] = wbRegData;
        end
        // A pop on this edge reads the file with this cycle's write forwarded
        loadArmed = rstN && !redirect && (!decValid || decReady);
        armedRegs = shadow;
    end

    initial begin
        rstN = 1'b0;
        wbDatIn = '0;
        wbAck = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        wbRegWrite = 1'b0;
        wbRegAddr = '0;
        wbRegData = '0;
        decReady = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
            loadedRegs[i] = 32'd0;
        end
        fillMemory();
        repeat (3) stepCycle();
        check("wbCyc in reset", 32'(wbCyc), 32'd0);
        check("wbStb in reset", 32'(wbStb), 32'd0);
        check("decValid in reset", 32'(decValid), 32'd0);
        rstN = 1'b1;
        stepCycle();
        check("decValid after reset", 32'(decValid), 32'd0);

        // Distinct starting values in x1 to x31
        for (int i = 1; i < 32; i++) begin
            stepCycle();
            wbRegWrite = 1'b1;
            wbRegAddr = 5'(i);
            wbRegData = {8'(i), 24'h5a0c3e};
        end
        randomWrites = 1'b1;
        repeat (150) stepCycle();

        waitFor(busOpen, "an open bus cycle");
        redirect = 1'b1;
        redirectPc = 32'h0000_0104;
        repeat (100) stepCycle();

        // Fill the queue so the bus goes quiet
        holdReady = 1'b1;
        repeat (20) stepCycle();
        waitFor(busIdle, "an idle bus");
        redirect = 1'b1;
        redirectPc = 32'h0000_0030;
        stepCycle();
        holdReady = 1'b0;
        repeat (100) stepCycle();

        transferGoal = transfers + 40;
        waitFor(enoughTransfers, "further transfers");
        $display("Checks %0d, errors %0d, timeouts %0d, transfers %0d",
            checks, errors, timeouts, transfers);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== hdl/rvDecodeTop.sv ====
// Fetch and decode front end
module rvDecodeTop import rvPkg::*; (
    input  logic                    clock,
    input  logic                    rstN,
    output logic                    wbCyc,
    output logic                    wbStb,
    output logic                    wbWe,
    output logic [xlen-1:0]         wbAdr,
    input  logic [xlen-1:0]         wbDatIn,
    input  logic                    wbAck,
    input  logic                    redirect,
    input  logic [xlen-1:0]         redirectPc,
    input  logic                    wbRegWrite,
    input  logic [regAddrWidth-1:0] wbRegAddr,
    input  logic [xlen-1:0]         wbRegData,
    input  logic                    decReady,
    output logic                    decValid,
    output logic [xlen-1:0]         decPc,
    output instrClass               decClass,
    output logic                    decRegWrite,
    output logic                    decAluSrc,
    output logic                    decMemRead,
    output logic                    decMemWrite,
    output memWidth                 decMemSize,
    output logic                    decMemUnsigned,
    output logic [3:0]              decFuncCode,
    output logic [regAddrWidth-1:0] decRs1,
    output logic [regAddrWidth-1:0] decRs2,
    output logic [regAddrWidth-1:0] decRd,
    output logic [xlen-1:0]         decRs1Data,
    output logic [xlen-1:0]         decRs2Data,
    output logic [xlen-1:0]         decImm
);

    logic                       push;
    logic                       pop;
    logic                       empty;
    logic [queueCountWidth-1:0] count;
    logic [xlen-1:0]            pushPc;
    logic [xlen-1:0]            pushInstr;
    logic [xlen-1:0]            headPc;
    logic [xlen-1:0]            headInstr;

    fetchUnit uFetch (
        .clock(clock), .rstN(rstN), .redirect(redirect), .redirectPc(redirectPc),
        .wbDatIn(wbDatIn), .wbAck(wbAck), .count(count),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .push(push), .pushPc(pushPc), .pushInstr(pushInstr)
    );

    // Redirect flushes everything between fetch and the decode output
    instrQueue uQueue (
        .clock(clock), .rstN(rstN), .flush(redirect),
        .push(push), .pushPc(pushPc), .pushInstr(pushInstr), .pop(pop),
        .headPc(headPc), .headInstr(headInstr), .count(count), .empty(empty)
    );

    decodeStage uDecode (
        .clock(clock), .rstN(rstN), .flush(redirect),
        .headPc(headPc), .headInstr(headInstr), .empty(empty), .decReady(decReady),
        .wbRegWrite(wbRegWrite), .wbRegAddr(wbRegAddr), .wbRegData(wbRegData),
        .pop(pop), .decValid(decValid), .decPc(decPc), .decClass(decClass),
        .decRegWrite(decRegWrite), .decAluSrc(decAluSrc),
        .decMemRead(decMemRead), .decMemWrite(decMemWrite),
        .decMemSize(decMemSize), .decMemUnsigned(decMemUnsigned),
        .decFuncCode(decFuncCode), .decRs1(decRs1), .decRs2(decRs2), .decRd(decRd),
        .decRs1Data(decRs1Data), .decRs2Data(decRs2Data), .decImm(decImm)
    );

endmodule

// ==== hdl/decodeStage.sv ====
// Decode stage
module decodeStage import rvPkg::*; (
    input  logic                    clock,
    input  logic                    rstN,
    input  logic                    flush,
    input  logic [xlen-1:0]         headPc,
    input  logic [xlen-1:0]         headInstr,
    input  logic                    empty,
    input  logic                    decReady,
    input  logic                    wbRegWrite,
    input  logic [regAddrWidth-1:0] wbRegAddr,
    input  logic [xlen-1:0]         wbRegData,
    output logic                    pop,
    output logic                    decValid,
    output logic [xlen-1:0]         decPc,
    output instrClass               decClass,
    output logic                    decRegWrite,
    output logic                    decAluSrc,
    output logic                    decMemRead,
    output logic                    decMemWrite,
    output memWidth                 decMemSize,
    output logic                    decMemUnsigned,
    output logic [3:0]              decFuncCode,
    output logic [regAddrWidth-1:0] decRs1,
    output logic [regAddrWidth-1:0] decRs2,
    output logic [regAddrWidth-1:0] decRd,
    output logic [xlen-1:0]         decRs1Data,
    output logic [xlen-1:0]         decRs2Data,
    output logic [xlen-1:0]         decImm
);

    instrClass       iClass;
    memWidth         memSize;
    logic            regWrite;
    logic            aluSrc;
    logic            memRead;
    logic            memWrite;
    logic            memUnsigned;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    logic            canLoad;

    // Output register is free or being drained this cycle
    assign canLoad = !decValid || decReady;
    assign pop     = !empty && canLoad && !flush;

    controlDecoder uCtrl (
        .instr(headInstr), .iClass(iClass), .regWrite(regWrite), .aluSrc(aluSrc),
        .memRead(memRead), .memWrite(memWrite), .memSize(memSize),
        .memUnsigned(memUnsigned)
    );

    immGen uImm (
        .instr(headInstr),
        .imm(imm)
    );

    registerFile uRegs (
        .clock(clock), .rstN(rstN),
        .rs1(headInstr[19:15]), .rs2(headInstr[24:20]),
        .writeEn(wbRegWrite), .writeAddr(wbRegAddr), .writeData(wbRegData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    always_ff @(posedge clock) begin
        if (!rstN || flush) begin
            decValid <= 1'b0;
        end else if (canLoad) begin
            decValid <= !empty;
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            decPc          <= headPc;
            decClass       <= iClass;
            decRegWrite    <= regWrite;
            decAluSrc      <= aluSrc;
            decMemRead     <= memRead;
            decMemWrite    <= memWrite;
            decMemSize     <= memSize;
            decMemUnsigned <= memUnsigned;
            decFuncCode    <= {headInstr[30], headInstr[14:12]};
            decRs1         <= headInstr[19:15];
            decRs2         <= headInstr[24:20];
            decRd          <= headInstr[11:7];
            decRs1Data     <= rs1Data;
            decRs2Data     <= rs2Data;
            decImm         <= imm;
        end
    end

    // Stalled output holds until the consumer takes it
    assert property (@(posedge clock) disable iff (!rstN)
        decValid && !decReady && !flush |=> decValid && $stable(decPc));

endmodule

// ==== hdl/registerFile.sv ====
// Integer register file
module registerFile import rvPkg::*; (
    input  logic                    clock,
    input  logic                    rstN,
    input  logic [regAddrWidth-1:0] rs1,
    input  logic [regAddrWidth-1:0] rs2,
    input  logic                    writeEn,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic [xlen-1:0]         writeData,
    output logic [xlen-1:0]         rs1Data,
    output logic [xlen-1:0]         rs2Data
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Same-cycle write is forwarded to the read ports
    always_comb begin
        if (rs1 == '0) begin
            rs1Data = '0;
        end else if (writeEn && writeAddr == rs1) begin
            rs1Data = writeData;
        end else begin
            rs1Data = regs[rs1];
        end
        if (rs2 == '0) begin
            rs2Data = '0;
        end else if (writeEn && writeAddr == rs2) begin
            rs2Data = writeData;
        end else begin
            rs2Data = regs[rs2];
        end
    end

endmodule

// ==== hdl/immGen.sv ====
// Immediate generator
module immGen import rvPkg::*; (
    input  logic [xlen-1:0] instr,
    output logic [xlen-1:0] imm
);

    logic [6:0] opcode;

    assign opcode = instr[6:0];

    always_comb begin
        case (opcode)
            // I format
            opOpImm, opLoad, opJalr:
                imm = {{20{instr[31]}}, instr[31:20]};
            opStore:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // Branch offset, bit 0 always zero
            opBranch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            opLui, opAuipc:
                imm = {instr[31:12], 12'b0};
            opJal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// ==== hdl/controlDecoder.sv ====
// RV32I control decoder
module controlDecoder import rvPkg::*; (
    input  logic [xlen-1:0] instr,
    output instrClass       iClass,
    output logic            regWrite,
    output logic            aluSrc,
    output logic            memRead,
    output logic            memWrite,
    output memWidth         memSize,
    output logic            memUnsigned
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        // Anything not matched below stays illegal with writes off
        iClass      = classIllegal;
        regWrite    = 1'b0;
        aluSrc      = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        memSize     = memNone;
        memUnsigned = 1'b0;
        case (opcode)
            opOp: begin
                iClass   = classAlu;
                regWrite = 1'b1;
            end
            opOpImm: begin
                iClass   = classAluImm;
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            opLoad: begin
                // LB LH LW LBU LHU only
                case (funct3)
                    3'd0, 3'd4: memSize = memByte;
                    3'd1, 3'd5: memSize = memHalf;
                    3'd2: memSize = memWord;
                    default: memSize = memNone;
                endcase
                if (memSize != memNone) begin
                    iClass      = classLoad;
                    regWrite    = 1'b1;
                    aluSrc      = 1'b1;
                    memRead     = 1'b1;
                    memUnsigned = funct3[2];
                end
            end
            opStore: begin
                case (funct3)
                    3'd0: memSize = memByte;
                    3'd1: memSize = memHalf;
                    3'd2: memSize = memWord;
                    default: memSize = memNone;
                endcase
                if (memSize != memNone) begin
                    iClass   = classStore;
                    aluSrc   = 1'b1;
                    memWrite = 1'b1;
                end
            end
            opBranch: iClass = classBranch;
            opJal: begin
                iClass   = classJal;
                regWrite = 1'b1;
            end
            opJalr: begin
                iClass   = classJalr;
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            opLui: begin
                iClass   = classLui;
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            opAuipc: begin
                iClass   = classAuipc;
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            default: iClass = classIllegal;
        endcase
    end

endmodule

// ==== hdl/instrQueue.sv ====
// Instruction queue
module instrQueue import rvPkg::*; (
    input  logic                       clock,
    input  logic                       rstN,
    input  logic                       flush,
    input  logic                       push,
    input  logic [xlen-1:0]            pushPc,
    input  logic [xlen-1:0]            pushInstr,
    input  logic                       pop,
    output logic [xlen-1:0]            headPc,
    output logic [xlen-1:0]            headInstr,
    output logic [queueCountWidth-1:0] count,
    output logic                       empty
);

    logic [xlen-1:0] pcMem [queueDepth];
    logic [xlen-1:0] instrMem [queueDepth];
    logic [$clog2(queueDepth)-1:0] wrPtr;
    logic [$clog2(queueDepth)-1:0] rdPtr;

    assign empty     = (count == '0);
    assign headPc    = pcMem[rdPtr];
    assign headInstr = instrMem[rdPtr];

    always_ff @(posedge clock) begin
        if (!rstN || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage has no reset
    always_ff @(posedge clock) begin
        if (push) begin
            pcMem[wrPtr]    <= pushPc;
            instrMem[wrPtr] <= pushInstr;
        end
    end

    // Fetch must respect the depth, decode must respect empty
    assert property (@(posedge clock) disable iff (!rstN)
        push |-> count != queueDepth);
    assert property (@(posedge clock) disable iff (!rstN)
        pop |-> !empty);

endmodule

// ==== hdl/fetchUnit.sv ====
// Instruction fetch over Wishbone
module fetchUnit import rvPkg::*; (
    input  logic                       clock,
    input  logic                       rstN,
    input  logic                       redirect,
    input  logic [xlen-1:0]            redirectPc,
    input  logic [xlen-1:0]            wbDatIn,
    input  logic                       wbAck,
    input  logic [queueCountWidth-1:0] count,
    output logic                       wbCyc,
    output logic                       wbStb,
    output logic                       wbWe,
    output logic [xlen-1:0]            wbAdr,
    output logic                       push,
    output logic [xlen-1:0]            pushPc,
    output logic [xlen-1:0]            pushInstr
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pendingPc;
    logic            busy;
    logic            dropPending;

    // One classic read at a time, address held until the ack
    assign wbCyc = busy;
    assign wbStb = busy;
    assign wbWe  = 1'b0;
    assign wbAdr = pc;

    // Word goes to the queue on its ack edge unless a redirect killed it
    assign push      = busy && wbAck && !dropPending;
    assign pushPc    = pc;
    assign pushInstr = wbDatIn;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc          <= resetPc;
            busy        <= 1'b0;
            dropPending <= 1'b0;
        end else if (busy) begin
            if (wbAck) begin
                busy        <= 1'b0;
                dropPending <= 1'b0;
                if (redirect) begin
                    pc <= {redirectPc[xlen-1:2], 2'b00};
                end else if (dropPending) begin
                    pc <= pendingPc;
                end else begin
                    pc <= pc + xlen'(4);
                end
            end else if (redirect) begin
                // Cycle still open, finish it and drop the word
                dropPending <= 1'b1;
            end
        end else if (redirect) begin
            pc <= {redirectPc[xlen-1:2], 2'b00};
        end else if (count < queueDepth) begin
            busy <= 1'b1;
        end
    end

    // Target for a redirect that arrived mid-cycle
    always_ff @(posedge clock) begin
        if (busy && !wbAck && redirect) begin
            pendingPc <= {redirectPc[xlen-1:2], 2'b00};
        end
    end

    // Memory may only acknowledge an open cycle
    assert property (@(posedge clock) disable iff (!rstN)
        wbAck |-> wbCyc && wbStb);

endmodule

// ==== hdl/rvPkg.sv ====
// RV32I front end definitions
package rvPkg;

    // Datapath and register index widths
    localparam int xlen = 32;
    localparam int regAddrWidth = 5;

    // Instruction queue sizing
    localparam int queueDepth = 4;
    localparam int queueCountWidth = 3;

    // First fetch address after reset
    localparam logic [xlen-1:0] resetPc = '0;

    // Decoded instruction class
    typedef enum logic [3:0] {
        classAlu,
        classAluImm,
        classLoad,
        classStore,
        classBranch,
        classJal,
        classJalr,
        classLui,
        classAuipc,
        classIllegal
    } instrClass;

    // Memory access size, memNone when there is no access
    typedef enum logic [1:0] {
        memByte,
        memHalf,
        memWord,
        memNone
    } memWidth;

    // RV32I major opcodes in instr[6:0]
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opOpImm  = 7'b0010011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111
    } rvOpcode;

endpackage
